// ==== exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath width
// the split adder is built as two 16 bit halves of this
`define EXEC_XLEN 32

// registers per hart context, x0 included
`define EXEC_NUM_REGS 8

// register index width, follows from the register count
`define EXEC_REG_AW ($clog2(`EXEC_NUM_REGS))

// hart contexts sharing the alu
`define EXEC_NUM_HARTS 2

// hart tag width, never below one bit
`define EXEC_HART_AW (($clog2(`EXEC_NUM_HARTS) > 0) ? $clog2(`EXEC_NUM_HARTS) : 1)

// immediate field of an issued instruction
`define EXEC_IMM_W 16

`endif

// ==== exec_pkg.sv ====
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

  // basic datapath types
  typedef logic [`EXEC_XLEN-1:0]    word_t;
  typedef logic [`EXEC_REG_AW-1:0]  reg_idx_t;
  typedef logic [`EXEC_HART_AW-1:0] hart_idx_t;

  // alu operations
  // compares return 0 or 1 in bit 0
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SEQ  = 4'd10,
    ALU_SNE  = 4'd11,
    ALU_SGE  = 4'd12,
    ALU_SGEU = 4'd13
  } alu_op_e;

  // serial alu sequencing, low half then high half
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_LOW  = 2'd1,
    ST_HIGH = 2'd2
  } alu_state_e;

  // instruction as issued to a hart
  typedef struct packed {
    alu_op_e                op;
    reg_idx_t               rd;
    reg_idx_t               rs1;
    reg_idx_t               rs2;
    logic                   use_imm;
    logic [`EXEC_IMM_W-1:0] imm;
  } issue_t;

  // operands already read, waiting for the shared alu
  typedef struct packed {
    alu_op_e  op;
    word_t    operand_a;
    word_t    operand_b;
    reg_idx_t rd;
  } alu_req_t;

  // result broadcast back to the harts
  typedef struct packed {
    hart_idx_t hart;
    reg_idx_t  rd;
    word_t     value;
  } wb_t;

endpackage

`default_nettype wire

// ==== serial_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module serial_alu
  import exec_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire          start_i,
  input  wire alu_op_e op_i,
  input  wire word_t   operand_a_i,
  input  wire word_t   operand_b_i,
  output word_t        result_o,
  output logic         done_o,
  output logic         busy_o
);

  localparam int HALF    = `EXEC_XLEN / 2;
  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  //////////////////////////////
  // sequencing and capture
  //////////////////////////////

  alu_state_e state_q;
  alu_state_e state_d;
  alu_op_e    op_q;
  word_t      a_q;
  word_t      b_q;
  logic       accept;

  // a start is only taken from idle
  assign accept = start_i && (state_q == ST_IDLE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (start_i)
        begin
          state_d = ST_LOW;
        end
      end
      ST_LOW:  state_d = ST_HIGH;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // operands stay put for both halves
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q <= op_i;
      a_q  <= operand_a_i;
      b_q  <= operand_b_i;
    end
  end

  //////////////////////////////
  // split adder
  //////////////////////////////

  logic          negate_b;
  word_t         b_add;
  logic [HALF:0] low_sum;
  logic [HALF:0] low_q;
  logic [HALF-1:0] high_sum;
  word_t         add_result;

  // sub and every compare run a - b
  always_comb
  begin
    case (op_q)
      ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU: negate_b = 1'b1;
      default: negate_b = 1'b0;
    endcase
  end

  // two's complement as inverted b plus a carry in on the low half
  assign b_add   = negate_b ? ~b_q : b_q;
  assign low_sum = {1'b0, a_q[HALF-1:0]} + {1'b0, b_add[HALF-1:0]} + {{HALF{1'b0}}, negate_b};

  // low half sum with its carry out in the top bit
  always_ff @(posedge clk)
  begin
    if (state_q == ST_LOW)
    begin
      low_q <= low_sum;
    end
  end

  // high half in the second cycle, carry from the flop
  assign high_sum   = a_q[`EXEC_XLEN-1:HALF] + b_add[`EXEC_XLEN-1:HALF]
                    + {{(HALF-1){1'b0}}, low_q[HALF]};
  assign add_result = {high_sum, low_q[HALF-1:0]};

  //////////////////////////////
  // shifter
  //////////////////////////////

  word_t                 a_rev;
  word_t                 shift_in;
  word_t                 shift_right;
  word_t                 shift_left;
  word_t                 shift_result;
  logic [2*`EXEC_XLEN-1:0] shift_ext;
  logic [2*`EXEC_XLEN-1:0] shift_wide;
  logic                  shift_l;
  logic                  shift_arith;

  assign shift_l     = (op_q == ALU_SLL);
  assign shift_arith = (op_q == ALU_SRA);

  // left shift = reverse, shift right, reverse back
  for (genvar k = 0; k < `EXEC_XLEN; k++)
  begin : g_rev
    assign a_rev[k]      = a_q[`EXEC_XLEN-1-k];
    assign shift_left[k] = shift_right[`EXEC_XLEN-1-k];
  end

  assign shift_in     = shift_l ? a_rev : a_q;
  // upper word holds the sign fill for sra
  assign shift_ext    = {{`EXEC_XLEN{shift_arith & shift_in[`EXEC_XLEN-1]}}, shift_in};
  assign shift_wide   = shift_ext >> b_q[SHAMT_W-1:0];
  assign shift_right  = shift_wide[`EXEC_XLEN-1:0];
  assign shift_result = shift_l ? shift_left : shift_right;

  //////////////////////////////
  // comparator
  //////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_ge;
  logic cmp_result;

  assign cmp_signed = (op_q == ALU_SLT) || (op_q == ALU_SGE);
  assign is_equal   = (add_result == '0);

  always_comb
  begin
    // same sign: no overflow, difference sign decides
    if (a_q[`EXEC_XLEN-1] == b_q[`EXEC_XLEN-1])
    begin
      is_ge = ~add_result[`EXEC_XLEN-1];
    end
    // signs differ: signed ge when b negative, unsigned ge when a has msb set
    else if (cmp_signed)
    begin
      is_ge = b_q[`EXEC_XLEN-1];
    end
    else
    begin
      is_ge = a_q[`EXEC_XLEN-1];
    end
  end

  always_comb
  begin
    case (op_q)
      ALU_SEQ:           cmp_result = is_equal;
      ALU_SNE:           cmp_result = ~is_equal;
      ALU_SGE, ALU_SGEU: cmp_result = is_ge;
      default:           cmp_result = ~is_ge;
    endcase
  end

  //////////////////////////////
  // result select
  //////////////////////////////

  always_comb
  begin
    result_o = add_result;
    case (op_q)
      ALU_AND: result_o = a_q & b_q;
      ALU_OR:  result_o = a_q | b_q;
      ALU_XOR: result_o = a_q ^ b_q;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU:
        result_o = {{(`EXEC_XLEN-1){1'b0}}, cmp_result};
      default: ;
    endcase
  end

  // result is only meaningful in the high half cycle
  assign done_o = (state_q == ST_HIGH);
  assign busy_o = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// ==== hart_ctx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module hart_ctx
  import exec_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         issue_valid_i,
  input  wire issue_t issue_i,
  input  wire         grant_i,
  input  wire         wb_valid_i,
  input  wire wb_t    wb_i,
  output logic        req_valid_o,
  output alu_req_t    req_o,
  output logic        busy_o
);

  // tag this context answers to on the writeback bus
  localparam hart_idx_t MY_TAG = hart_idx_t'(HART_ID);

  word_t    regs_q [`EXEC_NUM_REGS];
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm_ext;
  alu_req_t req_q;
  logic     req_valid_q;
  logic     busy_q;
  logic     accept;
  logic     wb_hit;

  // one instruction at a time so an issue while busy is dropped
  assign accept = issue_valid_i && !busy_q;
  assign wb_hit = wb_valid_i && (wb_i.hart == MY_TAG);

  //////////////////////////////
  // operand read
  //////////////////////////////

  // x0 reads as zero
  assign rs1_val = (issue_i.rs1 == '0) ? '0 : regs_q[issue_i.rs1];
  assign rs2_val = (issue_i.rs2 == '0) ? '0 : regs_q[issue_i.rs2];
  // sign extended immediate for operand b
  assign imm_ext = {{(`EXEC_XLEN-`EXEC_IMM_W){issue_i.imm[`EXEC_IMM_W-1]}}, issue_i.imm};

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `EXEC_NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    // result lands in rd and x0 is masked at the operand read
    else if (wb_hit)
    begin
      regs_q[wb_i.rd] <= wb_i.value;
    end
  end

  //////////////////////////////
  // pending request and busy
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
    end
    else if (accept)
    begin
      req_valid_q <= 1'b1;
      busy_q      <= 1'b1;
    end
    else
    begin
      // request leaves on grant while busy stays until the result lands
      if (grant_i)
      begin
        req_valid_q <= 1'b0;
      end
      if (wb_hit)
      begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_q.op        <= issue_i.op;
      req_q.operand_a <= rs1_val;
      req_q.operand_b <= issue_i.use_imm ? imm_ext : rs2_val;
      req_q.rd        <= issue_i.rd;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;
  assign busy_o      = busy_q;

endmodule

`default_nettype wire

// ==== alu_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module alu_arbiter
  import exec_pkg::*;
(
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire [`EXEC_NUM_HARTS-1:0]           req_valid_i,
  input  wire alu_req_t [`EXEC_NUM_HARTS-1:0] req_i,
  output logic [`EXEC_NUM_HARTS-1:0]          grant_o,
  output logic                                alu_start_o,
  output alu_op_e                             alu_op_o,
  output word_t                               alu_a_o,
  output word_t                               alu_b_o,
  input  wire                                 alu_busy_i,
  input  wire                                 alu_done_i,
  input  wire word_t                          alu_result_i,
  output logic                                wb_valid_o,
  output wb_t                                 wb_o
);

  localparam int unsigned NH = `EXEC_NUM_HARTS;

  hart_idx_t rr_ptr_q;
  hart_idx_t sel;
  logic      any_grant;
  hart_idx_t tag_q;
  reg_idx_t  rd_q;
  logic      wb_valid_q;
  wb_t       wb_q;

  //////////////////////////////
  // round robin grant
  //////////////////////////////

  // search starts at the pointer, first requester wins
  always_comb
  begin
    int unsigned cand;
    grant_o   = '0;
    sel       = rr_ptr_q;
    any_grant = 1'b0;
    cand      = 0;
    if (!alu_busy_i)
    begin
      for (int unsigned i = 0; i < NH; i++)
      begin
        cand = (32'(rr_ptr_q) + i) % NH;
        if (!any_grant && req_valid_i[cand])
        begin
          grant_o[cand] = 1'b1;
          sel           = hart_idx_t'(cand);
          any_grant     = 1'b1;
        end
      end
    end
  end

  // pointer moves past the winner so the loser goes first next time
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rr_ptr_q <= '0;
    end
    else if (any_grant)
    begin
      rr_ptr_q <= (sel == hart_idx_t'(NH - 1)) ? '0 : sel + 1'b1;
    end
  end

  // start goes out in the grant cycle
  assign alu_start_o = any_grant;
  assign alu_op_o    = req_i[sel].op;
  assign alu_a_o     = req_i[sel].operand_a;
  assign alu_b_o     = req_i[sel].operand_b;

  //////////////////////////////
  // result routing
  //////////////////////////////

  // owner of the operation in flight
  always_ff @(posedge clk)
  begin
    if (any_grant)
    begin
      tag_q <= sel;
      rd_q  <= req_i[sel].rd;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_valid_q <= 1'b0;
    end
    else
    begin
      wb_valid_q <= alu_done_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (alu_done_i)
    begin
      wb_q <= '{hart: tag_q, rd: rd_q, value: alu_result_i};
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

`default_nettype wire

// ==== dual_hart_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module dual_hart_exec
  import exec_pkg::*;
(
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire [`EXEC_NUM_HARTS-1:0]         issue_valid_i,
  input  wire issue_t [`EXEC_NUM_HARTS-1:0] issue_i,
  output logic [`EXEC_NUM_HARTS-1:0]        hart_busy_o,
  output logic                              wb_valid_o,
  output wb_t                               wb_o
);

  // hart side of the arbiter
  logic [`EXEC_NUM_HARTS-1:0]     req_valid;
  alu_req_t [`EXEC_NUM_HARTS-1:0] req;
  logic [`EXEC_NUM_HARTS-1:0]     grant;

  // shared alu
  logic    alu_start;
  alu_op_e alu_op;
  word_t   alu_a;
  word_t   alu_b;
  logic    alu_busy;
  logic    alu_done;
  word_t   alu_result;

  // one context per hart, writeback broadcast to all
  for (genvar h = 0; h < `EXEC_NUM_HARTS; h++)
  begin : g_hart
    hart_ctx #(
      .HART_ID (h)
    ) u_hart (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid_i (issue_valid_i[h]),
      .issue_i       (issue_i[h]),
      .grant_i       (grant[h]),
      .wb_valid_i    (wb_valid_o),
      .wb_i          (wb_o),
      .req_valid_o   (req_valid[h]),
      .req_o         (req[h]),
      .busy_o        (hart_busy_o[h])
    );
  end

  alu_arbiter u_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .grant_o      (grant),
    .alu_start_o  (alu_start),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_busy_i   (alu_busy),
    .alu_done_i   (alu_done),
    .alu_result_i (alu_result),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

  serial_alu u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (alu_start),
    .op_i        (alu_op),
    .operand_a_i (alu_a),
    .operand_b_i (alu_b),
    .result_o    (alu_result),
    .done_o      (alu_done),
    .busy_o      (alu_busy)
  );

endmodule

`default_nettype wire

// ==== exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_checker
  import exec_pkg::*;
(
  input wire                       clk,
  input wire                       rst_n,
  input wire [`EXEC_NUM_HARTS-1:0] grant_i,
  input wire                       start_i,
  input wire                       done_i,
  input wire                       wb_valid_i,
  input wire [`EXEC_NUM_HARTS-1:0] issue_valid_i,
  input wire [`EXEC_NUM_HARTS-1:0] hart_busy_i
);

  localparam int unsigned NH = `EXEC_NUM_HARTS;

  //////////////////////////////
  // arbiter and alu handshake
  //////////////////////////////

  // one hart at a time on the shared alu
  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant_i))
    else $error("more than one grant at once");

  // start only when no start was taken in the two edges before
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (!$past(start_i, 1) && !$past(start_i, 2)))
    else $error("start while the alu is busy");

  // low half lands at N+1 and done is seen at N+2
  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> ##2 done_i)
    else $error("done did not follow start by two edges");

  a_done_has_start: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(start_i, 2))
    else $error("done without a start two edges earlier");

  //////////////////////////////
  // writeback
  //////////////////////////////

  a_wb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_i |=> !wb_valid_i)
    else $error("writeback strobe longer than one cycle");

  // lone issue with every hart idle comes back after a fixed 3 cycles
  for (genvar h = 0; h < NH; h++)
  begin : g_latency
    a_uncontended: assert property (@(posedge clk) disable iff (!rst_n)
      (issue_valid_i == NH'(1 << h)) && (hart_busy_i == '0) |-> ##4 wb_valid_i)
      else $error("uncontended issue did not write back after 3 cycles");
  end

endmodule

`default_nettype wire

// ==== tb_dual_hart_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module tb_dual_hart_exec
  import exec_pkg::*;
();

  localparam int PERIOD          = 40;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

  logic                        clk;
  logic                        rst_n;
  logic [`EXEC_NUM_HARTS-1:0]  issue_valid;
  issue_t [`EXEC_NUM_HARTS-1:0] issue;
  logic [`EXEC_NUM_HARTS-1:0]  hart_busy;
  logic                        wb_valid;
  wb_t                         wb;

  // reference register files and outstanding predictions {rd, value}
  word_t       model [`EXEC_NUM_HARTS][`EXEC_NUM_REGS];
  logic [34:0] exp0 [$];
  logic [34:0] exp1 [$];
  int          errors;
  int          checks;
  int          base;
  int          last_grant;

  dual_hart_exec u_dual_hart_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .hart_busy_o   (hart_busy),
    .wb_valid_o    (wb_valid),
    .wb_o          (wb)
  );

  bind dual_hart_exec exec_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_i       (grant),
    .start_i       (alu_start),
    .done_i        (alu_done),
    .wb_valid_i    (wb_valid_o),
    .issue_valid_i (issue_valid_i),
    .hart_busy_i   (hart_busy_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic word_t predict_result(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
      ALU_SNE:  return (a != b) ? 32'd1 : 32'd0;
      ALU_SGE:  return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
      default:  return (a >= b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // sets up one hart's issue slot and records the predicted result
  task automatic load_slot(input int h, input alu_op_e op, input reg_idx_t rd,
                           input reg_idx_t rs1, input reg_idx_t rs2,
                           input logic use_imm, input logic [15:0] imm);
    word_t a;
    word_t b;
    logic [34:0] e;
    a = (rs1 == '0) ? '0 : model[h][rs1];
    b = use_imm ? {{16{imm[15]}}, imm} : ((rs2 == '0) ? '0 : model[h][rs2]);
    e = {rd, predict_result(op, a, b)};
    if (h == 0)
      exp0.push_back(e);
    else
      exp1.push_back(e);
    issue[h] = '{op: op, rd: rd, rs1: rs1, rs2: rs2, use_imm: use_imm, imm: imm};
    issue_valid[h] = 1'b1;
  endtask

  // one cycle strobe for every loaded slot
  task automatic fire();
    @(posedge clk);
    #2;
    issue_valid = '0;
  endtask

  task automatic wait_free(input int h);
    while (hart_busy[h])
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic run_rr(input int h, input alu_op_e op, input reg_idx_t rd,
                        input reg_idx_t rs1, input reg_idx_t rs2);
    wait_free(h);
    load_slot(h, op, rd, rs1, rs2, 1'b0, 16'h0);
    fire();
  endtask

  task automatic run_ri(input int h, input alu_op_e op, input reg_idx_t rd,
                        input reg_idx_t rs1, input logic [15:0] imm);
    wait_free(h);
    load_slot(h, op, rd, rs1, 3'd0, 1'b1, imm);
    fire();
  endtask

  // full 32 bit constant from three immediate ops
  // upper half pre-inverted when the low half sign extends
  task automatic load_value(input int h, input reg_idx_t rd, input word_t v);
    logic [15:0] hi;
    hi = v[15] ? ~v[31:16] : v[31:16];
    run_ri(h, ALU_ADD, rd, 3'd0, hi);
    run_ri(h, ALU_SLL, rd, rd, 16'd16);
    run_ri(h, ALU_XOR, rd, rd, v[15:0]);
  endtask

  task automatic drain();
    while ((hart_busy != '0) || (exp0.size() != 0) || (exp1.size() != 0))
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test(input int n, input string name);
    drain();
    $display("test %0d %s: %0d errors", n, name, errors - base);
    base = errors;
  endtask

  //////////////////////////////
  // response checking
  //////////////////////////////

  task automatic check_writeback();
    logic [34:0] e;
    int h;
    h = int'(wb.hart);
    if ((h == 0 && exp0.size() == 0) || (h == 1 && exp1.size() == 0))
    begin
      $display("writeback for hart %0d with nothing outstanding", h);
      errors++;
    end
    else
    begin
      e = (h == 0) ? exp0.pop_front() : exp1.pop_front();
      checks++;
      assert (wb.rd == e[34:32])
      else
      begin
        $display("Fail wb_o.rd hart %0d: got %h expected %h", h, wb.rd, e[34:32]);
        errors++;
      end
      assert (wb.value == e[31:0])
      else
      begin
        $display("Fail wb_o.value hart %0d: got %h expected %h", h, wb.value, e[31:0]);
        errors++;
      end
      // the hart stays busy up to the edge that writes its result
      assert (hart_busy[h] == 1'b1)
      else
      begin
        $display("Fail hart_busy_o[%0d]: got %h expected 1", h, hart_busy[h]);
        errors++;
      end
      // x0 stays zero in the model too
      if (e[34:32] != 3'd0)
        model[h][e[34:32]] = e[31:0];
    end
  endtask

  // sampled on the falling edge where registered outputs have settled
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      last_grant = 1;
    end
    else
    begin
      // with both harts waiting the previous loser must win
      if ((&u_dual_hart_exec.req_valid) && (|u_dual_hart_exec.grant))
      begin
        checks++;
        assert (!u_dual_hart_exec.grant[last_grant])
        else
        begin
          $display("grant did not alternate between the harts");
          errors++;
        end
      end
      if (u_dual_hart_exec.grant[0])
        last_grant = 0;
      else if (u_dual_hart_exec.grant[1])
        last_grant = 1;
      if (wb_valid)
        check_writeback();
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    word_t   a;
    word_t   b;
    alu_op_e logic_ops [6];
    alu_op_e cmp_ops [6];
    logic_ops = '{ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
    cmp_ops   = '{ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU};
    void'($urandom(48));
    errors      = 0;
    checks      = 0;
    base        = 0;
    rst_n       = 1'b0;
    issue_valid = '0;
    issue       = '0;
    for (int h = 0; h < `EXEC_NUM_HARTS; h++)
      for (int r = 0; r < `EXEC_NUM_REGS; r++)
        model[h][r] = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // test 1 covers quiet outputs after reset and x0 reads after a write to it
    checks++;
    assert ((wb_valid == 1'b0) && (hart_busy == '0))
    else
    begin
      $display("Fail wb_valid_o/hart_busy_o: got %h/%h expected 0/0", wb_valid, hart_busy);
      errors++;
    end
    run_ri(0, ALU_ADD, 3'd0, 3'd0, 16'h0005);
    run_rr(0, ALU_ADD, 3'd1, 3'd0, 3'd0);
    run_ri(1, ALU_ADD, 3'd0, 3'd0, 16'h7abc);
    run_rr(1, ALU_OR, 3'd2, 3'd0, 3'd0);
    end_test(1, "reset and x0");

    // test 2 runs add and sub where the first pairs carry and borrow across bit 15
    for (int i = 0; i < 4; i++)
    begin
      a = (i == 0) ? 32'h0000_ffff : (i == 1) ? 32'h0001_0000 : $urandom;
      b = (i < 2) ? 32'h0000_0001 : $urandom;
      load_value(i % 2, 3'd1, a);
      load_value(i % 2, 3'd2, b);
      run_rr(i % 2, ALU_ADD, 3'd3, 3'd1, 3'd2);
      run_rr(i % 2, ALU_SUB, 3'd4, 3'd1, 3'd2);
    end
    end_test(2, "add and sub");

    // test 3 runs logic ops and shifts with random register shift amounts 0 to 31
    for (int i = 0; i < 3; i++)
    begin
      a = $urandom;
      if (i == 0)
        a = a | 32'h8000_0000;
      load_value(0, 3'd1, a);
      load_value(0, 3'd2, $urandom);
      for (int k = 0; k < 6; k++)
        run_rr(0, logic_ops[k], 3'd3, 3'd1, 3'd2);
    end
    run_ri(0, ALU_SRA, 3'd4, 3'd1, 16'd0);
    run_ri(0, ALU_SRA, 3'd4, 3'd1, 16'd31);
    run_ri(0, ALU_SLL, 3'd4, 3'd1, 16'd31);
    run_ri(0, ALU_SRL, 3'd4, 3'd1, 16'd31);
    end_test(3, "logic and shifts");

    // test 4 runs compares with mixed signs and equal values
    for (int i = 0; i < 4; i++)
    begin
      a = $urandom;
      b = $urandom;
      case (i)
        0:
        begin
          a = a | 32'h8000_0000;
          b = b & 32'h7fff_ffff;
        end
        1:
        begin
          a = a & 32'h7fff_ffff;
          b = b | 32'h8000_0000;
        end
        2:       b = a;
        default: ;
      endcase
      load_value(1, 3'd1, a);
      load_value(1, 3'd2, b);
      for (int k = 0; k < 6; k++)
        run_rr(1, cmp_ops[k], 3'd3, 3'd1, 3'd2);
    end
    end_test(4, "compares");

    // test 5 is a dependent chain where each op reads the previous result
    run_ri(0, ALU_ADD, 3'd5, 3'd0, 16'd1);
    for (int i = 0; i < 6; i++)
    begin
      run_rr(0, ALU_ADD, 3'd5, 3'd5, 3'd5);
      run_rr(0, ALU_SUB, 3'd6, 3'd5, 3'd6);
    end
    end_test(5, "dependent chain");

    // test 6 has both harts issue in the same cycle
    for (int i = 0; i < 8; i++)
    begin
      wait_free(0);
      wait_free(1);
      load_slot(0, ALU_ADD, reg_idx_t'($urandom_range(7, 1)), reg_idx_t'($urandom_range(7, 0)),
                3'd0, 1'b1, 16'($urandom));
      load_slot(1, ALU_XOR, reg_idx_t'($urandom_range(7, 1)), reg_idx_t'($urandom_range(7, 0)),
                3'd0, 1'b1, 16'($urandom));
      fire();
    end
    end_test(6, "contention");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
exec_pkg.sv
serial_alu.sv
hart_ctx.sv
alu_arbiter.sv
dual_hart_exec.sv
exec_checker.sv
tb_dual_hart_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dual hart execute cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_dual_hart_exec \
  -o sim_dual_hart_exec

out="$(./obj_dir/sim_dual_hart_exec)"
echo "$out"

if grep -qx "No errors" <<< "$out"; then
  exit 0
else
  exit 1
fi
